//--- rtl/exu_alu_defs.svh
/*
 Widths and default sizes of the integer execute stage. EXU_PC_W must not
 exceed EXU_XLEN, because the link address is computed on the data adder.
*/

`ifndef EXU_ALU_DEFS_SVH
`define EXU_ALU_DEFS_SVH

// Register file data width
`define EXU_XLEN 32

// Destination register index width
`define EXU_RFIDX_W 5

// Program counter width
`define EXU_PC_W 32

// Default entries in the result FIFO
`define EXU_FIFO_DEPTH 4

`endif

//--- rtl/exu_alu_op_pkg.sv
/*
 Issue side types. The decoder is expected to drive rdwen low for branches.
 Any of the three fetch-exception flags overrides the group.
*/

`include "exu_alu_defs.svh"

package exu_alu_op_pkg;

  typedef enum logic {
    grp_alu = 1'b0,
    grp_bjp = 1'b1
  } grp_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_xor  = 4'd2,
    alu_sll  = 4'd3,
    alu_srl  = 4'd4,
    alu_sra  = 4'd5,
    alu_or   = 4'd6,
    alu_and  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_lui  = 4'd10   // op2 carries the shifted immediate
  } alu_op_e;

  typedef enum logic [2:0] {
    bjp_beq  = 3'd0,
    bjp_bne  = 3'd1,
    bjp_blt  = 3'd2,
    bjp_bge  = 3'd3,
    bjp_bltu = 3'd4,
    bjp_bgeu = 3'd5,
    bjp_jal  = 3'd6,
    bjp_jalr = 3'd7
  } bjp_op_e;

  typedef struct packed {
    grp_e                    grp;
    alu_op_e                 alu_op;
    bjp_op_e                 bjp_op;
    logic                    op2_imm;    // ALU takes imm instead of rs2
    logic                    bjp_prdt;   // Predicted taken
    logic [`EXU_XLEN-1:0]    rs1;
    logic [`EXU_XLEN-1:0]    rs2;
    logic [`EXU_XLEN-1:0]    imm;
    logic [`EXU_PC_W-1:0]    pc;
    logic [`EXU_RFIDX_W-1:0] rdidx;
    logic                    rdwen;
    logic                    ifu_ilegl;
    logic                    ifu_buserr;
    logic                    ifu_misalgn;
  } issue_t;

endpackage

//--- rtl/exu_alu_rslt_pkg.sv
/*
 Result side types. rslt_t is what the FIFO stores. cmt_t and wbck_t are the
 two views that the splitter drives out.
*/

`include "exu_alu_defs.svh"

package exu_alu_rslt_pkg;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]    wdat;
    logic [`EXU_RFIDX_W-1:0] rdidx;
    logic                    rdwen;
    logic                    err;        // Fetch exception, no write-back
    logic [`EXU_PC_W-1:0]    pc;
    logic                    bjp;
    logic                    bjp_prdt;
    logic                    bjp_rslv;   // Resolved taken
    logic                    ifu_ilegl;
    logic                    ifu_buserr;
    logic                    ifu_misalgn;
  } rslt_t;

  typedef struct packed {
    logic [`EXU_PC_W-1:0] pc;
    logic                 bjp;
    logic                 bjp_prdt;
    logic                 bjp_rslv;
    logic                 ifu_ilegl;
    logic                 ifu_buserr;
    logic                 ifu_misalgn;
  } cmt_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0]    wdat;
    logic [`EXU_RFIDX_W-1:0] rdidx;
  } wbck_t;

endpackage

//--- rtl/exu_alu_dpath.sv
/*
 Shared adder, comparator and shifter. Shift amount is the low log2(XLEN)
 bits of op2. Branch compares come from the adder's extra top bit.
*/
`timescale 1ns/1ps
`include "exu_alu_defs.svh"

module exu_alu_dpath (
  input  logic [`EXU_XLEN-1:0]    i_op1,
  input  logic [`EXU_XLEN-1:0]    i_op2,
  input  exu_alu_op_pkg::alu_op_e i_alu_op,
  input  exu_alu_op_pkg::bjp_op_e i_bjp_op,
  input  logic                    i_sel_bjp,   // Branch group owns the adder
  output logic [`EXU_XLEN-1:0]    o_alu_res,
  output logic [`EXU_XLEN-1:0]    o_add_res,
  output logic                    o_cmp_res
);

  localparam int SHAMT_W = $clog2(`EXU_XLEN);

  logic                 is_jump;
  logic                 do_sub;
  logic                 cmp_signed;
  logic [`EXU_XLEN:0]   add_op1;
  logic [`EXU_XLEN:0]   add_op2;
  logic [`EXU_XLEN:0]   add_sum;
  logic                 lt;
  logic                 eq;
  logic [`EXU_XLEN-1:0] shft_in;
  logic [`EXU_XLEN:0]   shft_ext;
  logic [`EXU_XLEN-1:0] shft_res;

  function automatic logic [`EXU_XLEN-1:0] bit_rev(input logic [`EXU_XLEN-1:0] v);
    logic [`EXU_XLEN-1:0] r;
    for (int k = 0; k < `EXU_XLEN; k++) begin
      r[k] = v[`EXU_XLEN-1-k];
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Adder and comparator

  assign is_jump = (i_bjp_op == exu_alu_op_pkg::bjp_jal) |
                   (i_bjp_op == exu_alu_op_pkg::bjp_jalr);
  assign do_sub  = i_sel_bjp ? ~is_jump :
                   (i_alu_op inside {exu_alu_op_pkg::alu_sub, exu_alu_op_pkg::alu_slt,
                                     exu_alu_op_pkg::alu_sltu});
  assign cmp_signed = i_sel_bjp ?
                      (i_bjp_op inside {exu_alu_op_pkg::bjp_blt, exu_alu_op_pkg::bjp_bge}) :
                      (i_alu_op == exu_alu_op_pkg::alu_slt);

  // One extra bit, sign or zero extended, makes the top bit the less-than flag
  assign add_op1 = {cmp_signed & i_op1[`EXU_XLEN-1], i_op1};
  assign add_op2 = {cmp_signed & i_op2[`EXU_XLEN-1], i_op2} ^ {(`EXU_XLEN+1){do_sub}};
  assign add_sum = add_op1 + add_op2 + {{`EXU_XLEN{1'b0}}, do_sub};

  assign lt        = add_sum[`EXU_XLEN];
  assign eq        = ~|add_sum[`EXU_XLEN-1:0];
  assign o_add_res = add_sum[`EXU_XLEN-1:0];

  always_comb begin
    case (i_bjp_op)
      exu_alu_op_pkg::bjp_beq:  o_cmp_res = eq;
      exu_alu_op_pkg::bjp_bne:  o_cmp_res = ~eq;
      exu_alu_op_pkg::bjp_blt,
      exu_alu_op_pkg::bjp_bltu: o_cmp_res = lt;
      exu_alu_op_pkg::bjp_bge,
      exu_alu_op_pkg::bjp_bgeu: o_cmp_res = ~lt;
      default:                  o_cmp_res = 1'b1;   // Jumps always taken
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Right shifter, left shifts go through it bit reversed

  assign shft_in  = (i_alu_op == exu_alu_op_pkg::alu_sll) ? bit_rev(i_op1) : i_op1;
  assign shft_ext = $signed({(i_alu_op == exu_alu_op_pkg::alu_sra) & i_op1[`EXU_XLEN-1],
                             shft_in}) >>> i_op2[SHAMT_W-1:0];
  assign shft_res = shft_ext[`EXU_XLEN-1:0];

  always_comb begin
    case (i_alu_op)
      exu_alu_op_pkg::alu_add,
      exu_alu_op_pkg::alu_sub:  o_alu_res = add_sum[`EXU_XLEN-1:0];
      exu_alu_op_pkg::alu_xor:  o_alu_res = i_op1 ^ i_op2;
      exu_alu_op_pkg::alu_or:   o_alu_res = i_op1 | i_op2;
      exu_alu_op_pkg::alu_and:  o_alu_res = i_op1 & i_op2;
      exu_alu_op_pkg::alu_sll:  o_alu_res = bit_rev(shft_res);
      exu_alu_op_pkg::alu_srl,
      exu_alu_op_pkg::alu_sra:  o_alu_res = shft_res;
      exu_alu_op_pkg::alu_slt,
      exu_alu_op_pkg::alu_sltu: o_alu_res = {{(`EXU_XLEN-1){1'b0}}, lt};
      exu_alu_op_pkg::alu_lui:  o_alu_res = i_op2;
      default:                  o_alu_res = '0;
    endcase
  end

endmodule

//--- rtl/exu_alu_exec.sv
/*
 One-entry execute register with a result one cycle after acceptance.
 A fetch exception skips the datapath and commits with err set and zero data.
 Branch wdat is the compare difference and is meant to be dropped by rdwen.
*/
`timescale 1ns/1ps
`include "exu_alu_defs.svh"

module exu_alu_exec (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  exu_alu_op_pkg::issue_t  i_issue,
  input  logic                    i_rslt_ready,
  output logic                    o_ready,
  output logic                    o_rslt_valid,
  output exu_alu_rslt_pkg::rslt_t o_rslt
);

  logic                    ifu_excp;
  logic                    sel_bjp;
  logic                    is_jump;
  logic [`EXU_XLEN-1:0]    op1;
  logic [`EXU_XLEN-1:0]    op2;
  logic [`EXU_XLEN-1:0]    alu_res;
  logic [`EXU_XLEN-1:0]    add_res;
  logic                    cmp_res;
  exu_alu_rslt_pkg::rslt_t rslt_nxt;
  logic                    full_q;
  exu_alu_rslt_pkg::rslt_t rslt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatch and operand selection

  assign ifu_excp = i_issue.ifu_ilegl | i_issue.ifu_buserr | i_issue.ifu_misalgn;
  assign sel_bjp  = ~ifu_excp & (i_issue.grp == exu_alu_op_pkg::grp_bjp);
  assign is_jump  = sel_bjp & ((i_issue.bjp_op == exu_alu_op_pkg::bjp_jal) |
                               (i_issue.bjp_op == exu_alu_op_pkg::bjp_jalr));

  always_comb begin
    if (ifu_excp) begin
      op1 = '0;   // Datapath left idle
      op2 = '0;
    end else if (is_jump) begin
      op1 = `EXU_XLEN'(i_issue.pc);
      op2 = `EXU_XLEN'(4);   // Link address pc+4
    end else if (sel_bjp || !i_issue.op2_imm) begin
      op1 = i_issue.rs1;
      op2 = i_issue.rs2;
    end else begin
      op1 = i_issue.rs1;
      op2 = i_issue.imm;
    end
  end

  exu_alu_dpath u_dpath (
    .i_op1     (op1),
    .i_op2     (op2),
    .i_alu_op  (i_issue.alu_op),
    .i_bjp_op  (i_issue.bjp_op),
    .i_sel_bjp (sel_bjp),
    .o_alu_res (alu_res),
    .o_add_res (add_res),
    .o_cmp_res (cmp_res)
  );

  always_comb begin
    if (ifu_excp) begin
      rslt_nxt.wdat = '0;
    end else if (sel_bjp) begin
      rslt_nxt.wdat = add_res;
    end else begin
      rslt_nxt.wdat = alu_res;
    end
    rslt_nxt.rdidx       = i_issue.rdidx;
    rslt_nxt.rdwen       = i_issue.rdwen;
    rslt_nxt.err         = ifu_excp;
    rslt_nxt.pc          = i_issue.pc;
    rslt_nxt.bjp         = sel_bjp;
    rslt_nxt.bjp_prdt    = i_issue.bjp_prdt;
    rslt_nxt.bjp_rslv    = sel_bjp & cmp_res;   // Jumps get 1 from the comparator
    rslt_nxt.ifu_ilegl   = i_issue.ifu_ilegl;
    rslt_nxt.ifu_buserr  = i_issue.ifu_buserr;
    rslt_nxt.ifu_misalgn = i_issue.ifu_misalgn;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register

  assign o_ready = ~full_q | i_rslt_ready;   // Empty or draining this cycle

  always_ff @(posedge clk) begin
    if (i_reset) begin
      full_q <= 1'b0;
    end else if (o_ready) begin
      full_q <= i_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      rslt_q <= rslt_nxt;
    end
  end

  assign o_rslt_valid = full_q;
  assign o_rslt       = rslt_q;

  a_rslt_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_rslt_valid && !i_rslt_ready |=> o_rslt_valid && $stable(o_rslt))
    else $error("execute result changed while stalled");

endmodule

//--- rtl/exu_alu_rslt_fifo.sv
/*
 Circular result buffer, DEPTH need not be a power of two. Write ready looks
 at occupancy only, so a full FIFO refuses a write even while it is read.
*/
`timescale 1ns/1ps
`include "exu_alu_defs.svh"

module exu_alu_rslt_fifo #(
  parameter int DEPTH = `EXU_FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_wr_valid,
  input  exu_alu_rslt_pkg::rslt_t i_wr_data,
  input  logic                    i_rd_ready,
  output logic                    o_wr_ready,
  output logic                    o_rd_valid,
  output exu_alu_rslt_pkg::rslt_t o_rd_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  exu_alu_rslt_pkg::rslt_t mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  logic                    wr_en;
  logic                    rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
  endfunction

  assign o_wr_ready = (count != CNT_W'(DEPTH));
  assign o_rd_valid = (count != '0);
  assign wr_en      = i_wr_valid & o_wr_ready;
  assign rd_en      = o_rd_valid & i_rd_ready;
  assign o_rd_data  = mem[rd_ptr];   // Head entry

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;   // Idle or pass through
      endcase
    end
  end

  a_count_max: assert property (@(posedge clk) disable iff (i_reset)
    count <= CNT_W'(DEPTH))
    else $error("result FIFO count above depth");

  a_rd_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_rd_valid && !i_rd_ready |=> o_rd_valid && $stable(o_rd_data))
    else $error("result FIFO head changed while stalled");

endmodule

//--- rtl/exu_alu_cmt_wbck.sv
/*
 Combinational split of one buffered result into commit and write-back.
 Each side is offered only when the other can also take it, so both finish
 in the same cycle. Entries with err set never write back.
*/
`timescale 1ns/1ps

module exu_alu_cmt_wbck (
  input  logic                    i_valid,
  input  exu_alu_rslt_pkg::rslt_t i_rslt,
  input  logic                    i_cmt_ready,
  input  logic                    i_wbck_ready,
  output logic                    o_ready,
  output logic                    o_cmt_valid,
  output exu_alu_rslt_pkg::cmt_t  o_cmt,
  output logic                    o_wbck_valid,
  output exu_alu_rslt_pkg::wbck_t o_wbck
);

  logic need_wbck;
  logic wbck_ok;   // Write-back ready or not involved

  assign need_wbck = i_rslt.rdwen & ~i_rslt.err;
  assign wbck_ok   = ~need_wbck | i_wbck_ready;

  // Paired valids
  assign o_cmt_valid  = i_valid & wbck_ok;
  assign o_wbck_valid = i_valid & need_wbck & i_cmt_ready;

  // Entry leaves when commit completes
  assign o_ready = i_cmt_ready & wbck_ok;

  always_comb begin
    o_cmt.pc          = i_rslt.pc;
    o_cmt.bjp         = i_rslt.bjp;
    o_cmt.bjp_prdt    = i_rslt.bjp_prdt;
    o_cmt.bjp_rslv    = i_rslt.bjp_rslv;
    o_cmt.ifu_ilegl   = i_rslt.ifu_ilegl;
    o_cmt.ifu_buserr  = i_rslt.ifu_buserr;
    o_cmt.ifu_misalgn = i_rslt.ifu_misalgn;
  end

  assign o_wbck.wdat  = i_rslt.wdat;
  assign o_wbck.rdidx = i_rslt.rdidx;

endmodule

//--- rtl/exu_alu_top.sv
/*
 Execute stage, result FIFO and commit/write-back splitter in series.
 Up to EXU_FIFO_DEPTH + 1 instructions in flight, results leave in order.
*/
`timescale 1ns/1ps
`include "exu_alu_defs.svh"

module exu_alu_top (
  input  logic                    clk,
  input  logic                    i_reset,
  input  logic                    i_valid,
  input  exu_alu_op_pkg::issue_t  i_issue,
  input  logic                    i_cmt_ready,
  input  logic                    i_wbck_ready,
  output logic                    o_ready,
  output logic                    o_cmt_valid,
  output exu_alu_rslt_pkg::cmt_t  o_cmt,
  output logic                    o_wbck_valid,
  output exu_alu_rslt_pkg::wbck_t o_wbck
);

  logic                    exec_valid;
  exu_alu_rslt_pkg::rslt_t exec_rslt;
  logic                    fifo_ready;
  logic                    fifo_valid;
  exu_alu_rslt_pkg::rslt_t fifo_rslt;
  logic                    split_ready;

  exu_alu_exec u_exec (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_issue      (i_issue),
    .i_rslt_ready (fifo_ready),
    .o_ready      (o_ready),
    .o_rslt_valid (exec_valid),
    .o_rslt       (exec_rslt)
  );

  exu_alu_rslt_fifo #(
    .DEPTH (`EXU_FIFO_DEPTH)
  ) u_rslt_fifo (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_wr_valid (exec_valid),
    .i_wr_data  (exec_rslt),
    .i_rd_ready (split_ready),
    .o_wr_ready (fifo_ready),
    .o_rd_valid (fifo_valid),
    .o_rd_data  (fifo_rslt)
  );

  exu_alu_cmt_wbck u_cmt_wbck (
    .i_valid      (fifo_valid),
    .i_rslt       (fifo_rslt),
    .i_cmt_ready  (i_cmt_ready),
    .i_wbck_ready (i_wbck_ready),
    .o_ready      (split_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck       (o_wbck)
  );

endmodule

//--- test/tb_exu_alu_vectors.svh
/*
 Instruction table, issued in row order. Branch rows keep rdwen low. Fault is
 {ilegl, buserr, misalgn}. Expected wdat is unused when no write-back is due.
*/

`ifndef TB_EXU_ALU_VECTORS_SVH
`define TB_EXU_ALU_VECTORS_SVH

  localparam int NUM_VECS = 28;

  // Row fields in order
  //   op, use_imm, prdt, rs1, rs2, imm, pc, rd, rdwen, fault,
  //   expected wdat, bjp_rslv, err, write-back
  task automatic load_vectors();
    ////////////////////////////////////////////////////////////////////////////
    // Regular ALU group
    add_row("add",  0, 0, 'h5, 'h7, 'h0, 'h1000, 1, 1, 0, 'hc, 0, 0, 1);
    add_row("add",  1, 0, 'h10, 'h99, 'hffff_fff0, 'h1004, 2, 1, 0, 'h0, 0, 0, 1);
    add_row("sub",  0, 0, 'h3, 'h5, 'h0, 'h1008, 3, 1, 0, 'hffff_fffe, 0, 0, 1);
    add_row("xor",  0, 0, 'hf0f0_1234, 'h0ff0_ffff, 'h0, 'h100c, 4, 1, 0, 'hff00_edcb, 0, 0, 1);
    add_row("or",   1, 0, 'h1200_0000, 'hdead, 'h34, 'h1010, 5, 1, 0, 'h1200_0034, 0, 0, 1);
    add_row("and",  0, 0, 'hff00_ff00, 'h0f0f_0f0f, 'h0, 'h1014, 6, 1, 0, 'h0f00_0f00, 0, 0, 1);
    add_row("sll",  0, 0, 'h3, 'h24, 'h0, 'h1018, 7, 1, 0, 'h30, 0, 0, 1);   // Upper shamt bits ignored
    add_row("srl",  0, 0, 'h8000_0000, 'h1f, 'h0, 'h101c, 8, 1, 0, 'h1, 0, 0, 1);
    add_row("sra",  0, 0, 'h8000_0000, 'h4, 'h0, 'h1020, 9, 1, 0, 'hf800_0000, 0, 0, 1);
    add_row("sra",  1, 0, 'h7000_0010, 'h1f, 'h4, 'h1024, 10, 1, 0, 'h0700_0001, 0, 0, 1);
    add_row("slt",  0, 0, 'hffff_ffff, 'h1, 'h0, 'h1028, 11, 1, 0, 'h1, 0, 0, 1);
    add_row("sltu", 0, 0, 'hffff_ffff, 'h1, 'h0, 'h102c, 12, 1, 0, 'h0, 0, 0, 1);
    add_row("slt",  1, 0, 'hffff_fff8, 'h0, 'hffff_fffb, 'h1030, 13, 1, 0, 'h1, 0, 0, 1);
    add_row("sltu", 0, 0, 'h1, 'h8000_0000, 'h0, 'h1034, 14, 1, 0, 'h1, 0, 0, 1);
    add_row("lui",  1, 0, 'h0, 'h0, 'habcd_e000, 'h1038, 15, 1, 0, 'habcd_e000, 0, 0, 1);
    add_row("add",  0, 0, 'h1, 'h2, 'h0, 'h103c, 16, 0, 0, 'h3, 0, 0, 0);   // No rd write

    ////////////////////////////////////////////////////////////////////////////
    // Branch and jump group
    add_row("beq",  0, 1, 'h55, 'h55, 'h0, 'h1040, 0, 0, 0, 'h0, 1, 0, 0);
    add_row("bne",  0, 1, 'h55, 'h55, 'h0, 'h1044, 0, 0, 0, 'h0, 0, 0, 0);
    add_row("blt",  0, 0, 'hffff_fff0, 'h1, 'h0, 'h1048, 0, 0, 0, 'h0, 1, 0, 0);
    add_row("bge",  0, 0, 'h8000_0000, 'h7fff_ffff, 'h0, 'h104c, 0, 0, 0, 'h0, 0, 0, 0);
    add_row("bltu", 0, 0, 'hffff_fff0, 'h1, 'h0, 'h1050, 0, 0, 0, 'h0, 0, 0, 0);
    add_row("bgeu", 0, 1, 'hffff_fff0, 'h1, 'h0, 'h1054, 0, 0, 0, 'h0, 1, 0, 0);
    add_row("bge",  0, 0, 'h7, 'h7, 'h0, 'h1058, 0, 0, 0, 'h0, 1, 0, 0);
    add_row("jal",  0, 1, 'h0, 'h0, 'h0, 'h2000, 1, 1, 0, 'h2004, 1, 0, 1);
    add_row("jalr", 0, 0, 'h1234, 'h0, 'h0, 'h3ffc, 31, 1, 0, 'h4000, 1, 0, 1);

    ////////////////////////////////////////////////////////////////////////////
    // Fetch exceptions, rdwen high on purpose
    add_row("add",  0, 0, 'h1, 'h2, 'h0, 'h1060, 3, 1, 'b100, 'h0, 0, 1, 0);
    add_row("jal",  0, 1, 'h0, 'h0, 'h0, 'h1064, 1, 1, 'b010, 'h0, 0, 1, 0);
    add_row("beq",  0, 0, 'h9, 'h9, 'h0, 'h1068, 0, 0, 'b001, 'h0, 0, 1, 0);
  endtask

`endif

//--- test/tb_exu_alu.sv
/*
 Issues every table row in order while commit and write-back ready toggle at
 random, and checks each commit and write-back against the table.
 Stops at the first mismatch. Reset must last at least one clock edge.
*/
`timescale 1ns/1ps
`include "exu_alu_defs.svh"

module tb_exu_alu;

  `include "tb_exu_alu_vectors.svh"

  localparam int TIMEOUT_CYCLES = 20 * NUM_VECS + 100;

  typedef struct packed {
    exu_alu_op_pkg::issue_t issue;
    logic [`EXU_XLEN-1:0]   exp_wdat;
    logic                   exp_rslv;
    logic                   exp_err;
    logic                   exp_wbck;
  } vec_t;

  typedef struct packed {
    exu_alu_rslt_pkg::cmt_t  cmt;
    exu_alu_rslt_pkg::wbck_t wbck;
    logic                    has_wbck;
    int                      row;
  } exp_t;

  logic                    clk;
  logic                    i_reset;
  logic                    i_valid;
  exu_alu_op_pkg::issue_t  i_issue;
  logic                    i_cmt_ready;
  logic                    i_wbck_ready;
  logic                    o_ready;
  logic                    o_cmt_valid;
  exu_alu_rslt_pkg::cmt_t  o_cmt;
  logic                    o_wbck_valid;
  exu_alu_rslt_pkg::wbck_t o_wbck;

  vec_t   vectors [NUM_VECS];
  int     vec_cnt = 0;
  exp_t   sb_q [$];   // Expected results, table order
  int     cmt_cnt = 0;
  int     cycle_cnt = 0;
  integer seed = 32'ha05c4cb7;

  exu_alu_top i_exu_alu_top (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_issue      (i_issue),
    .i_cmt_ready  (i_cmt_ready),
    .i_wbck_ready (i_wbck_ready),
    .o_ready      (o_ready),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck       (o_wbck)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table rows and expected results

  task automatic add_row(
    input logic [8*4-1:0]          mnem,
    input logic                    use_imm,
    input logic                    prdt,
    input logic [`EXU_XLEN-1:0]    rs1,
    input logic [`EXU_XLEN-1:0]    rs2,
    input logic [`EXU_XLEN-1:0]    imm,
    input logic [`EXU_PC_W-1:0]    pc,
    input logic [`EXU_RFIDX_W-1:0] rdidx,
    input logic                    rdwen,
    input logic [2:0]              fault,
    input logic [`EXU_XLEN-1:0]    exp_wdat,
    input logic                    exp_rslv,
    input logic                    exp_err,
    input logic                    exp_wbck
  );
    vec_t v;
    logic known;
    v     = '0;
    known = 1'b1;
    v.issue.grp = exu_alu_op_pkg::grp_bjp;
    case (mnem)
      "beq":   v.issue.bjp_op = exu_alu_op_pkg::bjp_beq;
      "bne":   v.issue.bjp_op = exu_alu_op_pkg::bjp_bne;
      "blt":   v.issue.bjp_op = exu_alu_op_pkg::bjp_blt;
      "bge":   v.issue.bjp_op = exu_alu_op_pkg::bjp_bge;
      "bltu":  v.issue.bjp_op = exu_alu_op_pkg::bjp_bltu;
      "bgeu":  v.issue.bjp_op = exu_alu_op_pkg::bjp_bgeu;
      "jal":   v.issue.bjp_op = exu_alu_op_pkg::bjp_jal;
      "jalr":  v.issue.bjp_op = exu_alu_op_pkg::bjp_jalr;
      default: v.issue.grp = exu_alu_op_pkg::grp_alu;
    endcase
    case (mnem)
      "add":   v.issue.alu_op = exu_alu_op_pkg::alu_add;
      "sub":   v.issue.alu_op = exu_alu_op_pkg::alu_sub;
      "xor":   v.issue.alu_op = exu_alu_op_pkg::alu_xor;
      "or":    v.issue.alu_op = exu_alu_op_pkg::alu_or;
      "and":   v.issue.alu_op = exu_alu_op_pkg::alu_and;
      "sll":   v.issue.alu_op = exu_alu_op_pkg::alu_sll;
      "srl":   v.issue.alu_op = exu_alu_op_pkg::alu_srl;
      "sra":   v.issue.alu_op = exu_alu_op_pkg::alu_sra;
      "slt":   v.issue.alu_op = exu_alu_op_pkg::alu_slt;
      "sltu":  v.issue.alu_op = exu_alu_op_pkg::alu_sltu;
      "lui":   v.issue.alu_op = exu_alu_op_pkg::alu_lui;
      default: known = (v.issue.grp == exu_alu_op_pkg::grp_bjp);
    endcase
    if (!known || vec_cnt >= NUM_VECS) begin
      fail_run($sformatf("Table row %0d has an unknown op or exceeds the table size", vec_cnt));
    end
    v.issue.op2_imm     = use_imm;
    v.issue.bjp_prdt    = prdt;
    v.issue.rs1         = rs1;
    v.issue.rs2         = rs2;
    v.issue.imm         = imm;
    v.issue.pc          = pc;
    v.issue.rdidx       = rdidx;
    v.issue.rdwen       = rdwen;
    v.issue.ifu_ilegl   = fault[2];
    v.issue.ifu_buserr  = fault[1];
    v.issue.ifu_misalgn = fault[0];
    v.exp_wdat          = exp_wdat;
    v.exp_rslv          = exp_rslv;
    v.exp_err           = exp_err;
    v.exp_wbck          = exp_wbck;
    vectors[vec_cnt]    = v;
    vec_cnt++;
  endtask

  function automatic exp_t expect_of(input vec_t v, input int row);
    exp_t e;
    e.cmt.pc          = v.issue.pc;
    e.cmt.bjp         = (v.issue.grp == exu_alu_op_pkg::grp_bjp) & ~v.exp_err;
    e.cmt.bjp_prdt    = v.issue.bjp_prdt;
    e.cmt.bjp_rslv    = v.exp_rslv;
    e.cmt.ifu_ilegl   = v.issue.ifu_ilegl;
    e.cmt.ifu_buserr  = v.issue.ifu_buserr;
    e.cmt.ifu_misalgn = v.issue.ifu_misalgn;
    e.wbck.wdat       = v.exp_wdat;
    e.wbck.rdidx      = v.issue.rdidx;
    e.has_wbck        = v.exp_wbck;
    e.row             = row;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checkers

  task automatic check_cmt(input exu_alu_rslt_pkg::cmt_t got,
                           input exu_alu_rslt_pkg::cmt_t exp, input int row);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] o_cmt row %0d got 0x%h expected 0x%h", row, got, exp));
    end
  endtask

  task automatic check_wbck(input exu_alu_rslt_pkg::wbck_t got,
                            input exu_alu_rslt_pkg::wbck_t exp, input int row);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] o_wbck row %0d got 0x%h expected 0x%h", row, got, exp));
    end
  endtask

  task automatic check_idle();
    logic [2:0] flags;
    flags = {o_cmt_valid, o_wbck_valid, o_ready};
    if (flags !== 3'b001) begin
      fail_run($sformatf("[ERROR] {o_cmt_valid, o_wbck_valid, o_ready} got 0x%h expected 0x1",
                         flags));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Timeout from the table length
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d rows committed",
                         cycle_cnt, cmt_cnt, NUM_VECS));
    end
  end

  // Outputs are sampled mid cycle, a handshake completes at the next edge
  always @(negedge clk) begin : monitor
    exp_t e;
    if (i_reset) begin
      if (cycle_cnt > 0) begin
        check_idle();
      end
    end else begin
      if (o_wbck_valid && (sb_q.size() == 0 || !sb_q[0].has_wbck)) begin
        fail_run("Write-back offered for an instruction that must not write back");
      end
      if (o_cmt_valid && i_cmt_ready) begin
        if (sb_q.size() == 0) begin
          fail_run("Commit seen with no instruction outstanding");
        end
        e = sb_q.pop_front();
        check_cmt(o_cmt, e.cmt, e.row);
        if (e.has_wbck) begin
          if (!(o_wbck_valid && i_wbck_ready)) begin
            fail_run($sformatf("Row %0d committed without its write-back", e.row));
          end
          check_wbck(o_wbck, e.wbck, e.row);
        end
        cmt_cnt++;
      end else if (o_wbck_valid && i_wbck_ready) begin
        fail_run("Write-back completed without its commit");
      end
    end
  end

  // Random back-pressure once reset is over
  initial begin
    @(negedge i_reset);
    forever begin
      @(posedge clk);
      #1;
      i_cmt_ready  = ($random(seed) & 3) != 0;
      i_wbck_ready = ($random(seed) & 3) != 0;
    end
  end

  initial begin : stimulus
    logic accepted;
    i_reset      = 1'b1;
    i_valid      = 1'b0;
    i_issue      = '0;
    i_cmt_ready  = 1'b0;
    i_wbck_ready = 1'b0;
    load_vectors();
    if (vec_cnt != NUM_VECS) begin
      fail_run($sformatf("Table holds %0d rows but NUM_VECS is %0d", vec_cnt, NUM_VECS));
    end
    for (int n = 0; n < NUM_VECS; n++) begin
      sb_q.push_back(expect_of(vectors[n], n));
    end

    repeat (8) @(posedge clk);
    #1;
    i_reset = 1'b0;
    @(negedge clk);
    check_idle();   // First cycle out of reset
    @(posedge clk);
    #1;

    for (int n = 0; n < NUM_VECS; n++) begin
      i_valid  = 1'b1;
      i_issue  = vectors[n].issue;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = o_ready;
        @(posedge clk);
        #1;
      end
    end
    i_valid = 1'b0;
    i_issue = '0;

    while (cmt_cnt < NUM_VECS) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);   // Catch stray commits
    if (cmt_cnt == NUM_VECS && sb_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_run($sformatf("Committed %0d rows, expected %0d", cmt_cnt, NUM_VECS));
    end
  end

endmodule

//--- exu_alu.f
+incdir+rtl
+incdir+test
rtl/exu_alu_op_pkg.sv
rtl/exu_alu_rslt_pkg.sv
rtl/exu_alu_dpath.sv
rtl/exu_alu_exec.sv
rtl/exu_alu_rslt_fifo.sv
rtl/exu_alu_cmt_wbck.sv
rtl/exu_alu_top.sv
test/tb_exu_alu.sv

//--- Bender.yml
package:
  name: exu_alu

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/exu_alu_op_pkg.sv
      - rtl/exu_alu_rslt_pkg.sv
      - rtl/exu_alu_dpath.sv
      - rtl/exu_alu_exec.sv
      - rtl/exu_alu_rslt_fifo.sv
      - rtl/exu_alu_cmt_wbck.sv
      - rtl/exu_alu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_exu_alu.sv
